//--- mmio_pkg.sv
package mmio_pkg;

    typedef logic [31:0] word_t;  // data word on every bus
    typedef logic [31:0] addr_t;  // byte address from memory handler

    localparam int TIMER_W     = 5;   // wait counter width
    localparam int MEM_TIMEOUT = 16;  // wait cycles before giving up on memory

    typedef logic [TIMER_W-1:0] wait_cnt_t;
    typedef logic [7:0]         spi_cmd_t;  // display controller opcode
    typedef logic [3:0]         spi_cnt_t;  // parameter byte count

    // address map
    localparam addr_t MEM_LIMIT      = 32'd2048;    // data memory below this
    localparam addr_t SPI_CMD_ADDR   = 32'd121212;  // command + counter
    localparam addr_t SPI_PARAM_ADDR = 32'd333333;  // parameters, kicks off spi
    localparam addr_t I2C_XY_ADDR    = 32'd923923;  // touch x/y, read only

    localparam word_t ERR_WORD = 32'hDEADBEEF;  // returned when memory times out

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mmio_req_t;

    typedef struct packed {
        logic  rd_stb;  // one cycle
        logic  wr_stb;  // one cycle
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        spi_cmd_t command;
        spi_cnt_t counter;
        word_t    parameters;
    } spi_cfg_t;

    typedef enum logic [2:0] {REG_MEM, REG_SPI_CMD, REG_SPI_PARAM, REG_I2C, REG_NONE} region_t;
    typedef enum logic [1:0] {K_IDLE, K_READ, K_WRITE} kind_t;
    typedef enum logic [2:0] {IDLE, MEMWAIT, MEMREAD, MEMWRITE, BUSY} mmio_state_t;

endpackage

//--- mmio_decode.sv
`timescale 1ns/1ps

module mmio_decode (
    input  mmio_pkg::mmio_req_t mmio_req_i,
    output mmio_pkg::region_t   region_o,
    output mmio_pkg::kind_t     kind_o
);

    logic is_rd;
    logic is_wr;

    // exactly one of read/write makes a real request
    assign is_rd = mmio_req_i.read && !mmio_req_i.write;
    assign is_wr = mmio_req_i.write && !mmio_req_i.read;

    always_comb begin
        kind_o = mmio_pkg::K_IDLE;  // both or neither
        if (is_rd) begin
            kind_o = mmio_pkg::K_READ;
        end else if (is_wr) begin
            kind_o = mmio_pkg::K_WRITE;
        end
    end

    // register addresses win over the memory range
    always_comb begin
        region_o = mmio_pkg::REG_NONE;
        if (mmio_req_i.addr == mmio_pkg::SPI_CMD_ADDR) begin
            region_o = is_wr ? mmio_pkg::REG_SPI_CMD : mmio_pkg::REG_NONE;  // write only
        end else if (mmio_req_i.addr == mmio_pkg::SPI_PARAM_ADDR) begin
            region_o = is_wr ? mmio_pkg::REG_SPI_PARAM : mmio_pkg::REG_NONE;
        end else if (mmio_req_i.addr == mmio_pkg::I2C_XY_ADDR) begin
            region_o = is_rd ? mmio_pkg::REG_I2C : mmio_pkg::REG_NONE;  // sensor word is read only
        end else if (mmio_req_i.addr < mmio_pkg::MEM_LIMIT) begin
            region_o = mmio_pkg::REG_MEM;
        end
    end

endmodule

//--- mmio_fsm.sv
`timescale 1ns/1ps

module mmio_fsm (
    input  logic                clk,
    input  logic                nRst,
    input  mmio_pkg::mmio_req_t mmio_req_i,
    input  mmio_pkg::region_t   region_i,
    input  mmio_pkg::kind_t     kind_i,
    input  logic                mem_busy_i,
    input  mmio_pkg::word_t     mem_rdata_i,
    input  logic                i2c_done_i,
    input  mmio_pkg::word_t     i2c_xy_i,
    input  logic                spi_busy_i,
    input  logic                timeout_i,
    output mmio_pkg::mem_req_t  mem_o,
    output logic                timer_run_o,
    output logic                spi_load_o,
    output logic                busy_o,
    output logic                done_o,
    output mmio_pkg::word_t     rdata_o
);

    mmio_pkg::mmio_state_t state_q, next_state;

    logic            accept_mem;  // memory request taken this cycle
    logic            accept_reg;  // register type request taken this cycle
    logic            rd_stb_q, wr_stb_q;
    mmio_pkg::addr_t mem_addr_q;
    mmio_pkg::word_t mem_wdata_q;
    mmio_pkg::word_t rdata_q;

    always_comb begin
        next_state = state_q;
        accept_mem = 1'b0;
        accept_reg = 1'b0;
        case (state_q)
            mmio_pkg::IDLE: begin
                if (kind_i != mmio_pkg::K_IDLE) begin
                    case (region_i)
                        mmio_pkg::REG_MEM:       accept_mem = !mem_busy_i;
                        mmio_pkg::REG_SPI_PARAM: accept_reg = !spi_busy_i;  // wait for spi idle
                        mmio_pkg::REG_I2C:       accept_reg = i2c_done_i;   // wait for valid x/y
                        default:                 accept_reg = 1'b1;  // spi cmd, unmapped
                    endcase
                end
                if (accept_mem) begin
                    next_state = mmio_pkg::MEMWAIT;
                end else if (accept_reg) begin
                    next_state = mmio_pkg::BUSY;
                end
            end
            // strobe cycle, busy shows up next cycle
            mmio_pkg::MEMWAIT: next_state = rd_stb_q ? mmio_pkg::MEMREAD : mmio_pkg::MEMWRITE;
            mmio_pkg::MEMREAD, mmio_pkg::MEMWRITE: begin
                if (!mem_busy_i || timeout_i) begin
                    next_state = mmio_pkg::BUSY;
                end
            end
            mmio_pkg::BUSY: next_state = mmio_pkg::IDLE;  // done pulse
            default:        next_state = mmio_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state_q  <= mmio_pkg::IDLE;
            rd_stb_q <= 1'b0;
            wr_stb_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            state_q  <= next_state;
            rd_stb_q <= accept_mem && (kind_i == mmio_pkg::K_READ);   // high in MEMWAIT only
            wr_stb_q <= accept_mem && (kind_i == mmio_pkg::K_WRITE);
            if (accept_reg && region_i == mmio_pkg::REG_I2C) begin
                rdata_q <= i2c_xy_i;
            end else if (accept_reg && region_i == mmio_pkg::REG_NONE
                         && kind_i == mmio_pkg::K_READ) begin
                rdata_q <= '0;  // unmapped read
            end else if (state_q == mmio_pkg::MEMREAD && next_state == mmio_pkg::BUSY) begin
                rdata_q <= mem_busy_i ? mmio_pkg::ERR_WORD : mem_rdata_i;  // busy still high means timeout
            end
        end
    end

    // address and data for the memory, held over the access
    always_ff @(posedge clk) begin
        if (accept_mem) begin
            mem_addr_q  <= mmio_req_i.addr;
            mem_wdata_q <= mmio_req_i.wdata;
        end
    end

    assign mem_o.rd_stb = rd_stb_q;
    assign mem_o.wr_stb = wr_stb_q;
    assign mem_o.addr   = mem_addr_q;
    assign mem_o.wdata  = mem_wdata_q;

    assign timer_run_o = (state_q == mmio_pkg::MEMREAD) || (state_q == mmio_pkg::MEMWRITE);
    assign spi_load_o  = accept_reg && (region_i == mmio_pkg::REG_SPI_CMD
                                        || region_i == mmio_pkg::REG_SPI_PARAM);
    assign busy_o  = (state_q != mmio_pkg::IDLE);
    assign done_o  = (state_q == mmio_pkg::BUSY);
    assign rdata_o = rdata_q;

    a_done_single: assert property (@(posedge clk) disable iff (!nRst)
        done_o |=> !done_o)
        else $error("done_o high two cycles in a row");

    // memory must be idle whenever a new access is strobed
    a_no_stb_busy: assert property (@(posedge clk) disable iff (!nRst)
        (mem_o.rd_stb || mem_o.wr_stb) |-> !mem_busy_i)
        else $error("memory strobe while mem_busy_i high");

endmodule

//--- mmio_wait_timer.sv
`timescale 1ns/1ps

module mmio_wait_timer (
    input  logic clk,
    input  logic nRst,
    input  logic run_i,      // fsm sits in a memory wait state
    output logic timeout_o
);

    mmio_pkg::wait_cnt_t cnt_q;
    logic                at_limit;

    assign at_limit = (cnt_q == mmio_pkg::wait_cnt_t'(mmio_pkg::MEM_TIMEOUT));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;  // clear between accesses
        end else if (!at_limit) begin
            cnt_q <= cnt_q + 1'b1;  // saturate at the limit
        end
    end

    // count can sit at the limit for one cycle after run drops
    assign timeout_o = run_i && at_limit;

    // a timeout only after run held for the full wait window
    a_timeout_run: assert property (@(posedge clk) disable iff (!nRst)
        $rose(timeout_o) |-> run_i && $past(run_i, mmio_pkg::MEM_TIMEOUT))
        else $error("timeout_o rose without a full wait window");

endmodule

//--- spi_cfg_regs.sv
`timescale 1ns/1ps

module spi_cfg_regs (
    input  logic               clk,
    input  logic               nRst,
    input  logic               load_i,    // accept edge of an spi write
    input  mmio_pkg::region_t  region_i,
    input  mmio_pkg::word_t    wdata_i,
    output mmio_pkg::spi_cfg_t spi_cfg_o,
    output logic               spi_start_o
);

    mmio_pkg::spi_cfg_t cfg_q;
    logic               start_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            cfg_q   <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;  // one cycle pulse
            if (load_i) begin
                case (region_i)
                    mmio_pkg::REG_SPI_CMD: begin
                        cfg_q.command <= wdata_i[7:0];
                        cfg_q.counter <= wdata_i[11:8];  // no start on command write
                    end
                    mmio_pkg::REG_SPI_PARAM: begin
                        cfg_q.parameters <= wdata_i;
                        start_q          <= 1'b1;  // lines up with done
                    end
                    default: ;  // other regions leave the fields alone
                endcase
            end
        end
    end

    assign spi_cfg_o   = cfg_q;
    assign spi_start_o = start_q;

endmodule

//--- mmio_top.sv
`timescale 1ns/1ps

module mmio_top (
    input  logic                clk,
    input  logic                nRst,
    // memory handler
    input  mmio_pkg::mmio_req_t mmio_req_i,
    output logic                busy_o,
    output logic                done_o,
    output mmio_pkg::word_t     rdata_o,
    // data memory
    output mmio_pkg::mem_req_t  mem_o,
    input  logic                mem_busy_i,
    input  mmio_pkg::word_t     mem_rdata_i,
    // spi display
    output mmio_pkg::spi_cfg_t  spi_cfg_o,
    output logic                spi_start_o,
    input  logic                spi_busy_i,
    // i2c touch
    input  mmio_pkg::word_t     i2c_xy_i,
    input  logic                i2c_done_i
);

    mmio_pkg::region_t region;
    mmio_pkg::kind_t   kind;
    logic              timer_run;
    logic              timeout;
    logic              spi_load;

    mmio_decode mmio_decode_inst (
        .mmio_req_i (mmio_req_i),
        .region_o   (region),
        .kind_o     (kind)
    );

    mmio_fsm mmio_fsm_inst (
        .clk         (clk),
        .nRst        (nRst),
        .mmio_req_i  (mmio_req_i),
        .region_i    (region),
        .kind_i      (kind),
        .mem_busy_i  (mem_busy_i),
        .mem_rdata_i (mem_rdata_i),
        .i2c_done_i  (i2c_done_i),
        .i2c_xy_i    (i2c_xy_i),
        .spi_busy_i  (spi_busy_i),
        .timeout_i   (timeout),
        .mem_o       (mem_o),
        .timer_run_o (timer_run),
        .spi_load_o  (spi_load),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o)
    );

    mmio_wait_timer mmio_wait_timer_inst (
        .clk       (clk),
        .nRst      (nRst),
        .run_i     (timer_run),
        .timeout_o (timeout)
    );

    // spi fields come straight from the handler write data
    spi_cfg_regs spi_cfg_regs_inst (
        .clk         (clk),
        .nRst        (nRst),
        .load_i      (spi_load),
        .region_i    (region),
        .wdata_i     (mmio_req_i.wdata),
        .spi_cfg_o   (spi_cfg_o),
        .spi_start_o (spi_start_o)
    );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_NS = 4  // 8 ns period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(HALF_NS) clk_o = ~clk_o;
    end

endmodule

//--- mmio_checker.sv
`timescale 1ns/1ps

module mmio_checker (
    input  logic                clk,
    input  logic                nRst,
    input  mmio_pkg::mmio_req_t req_i,
    input  logic                busy_i,
    input  logic                done_i,
    input  mmio_pkg::word_t     rdata_i,
    input  mmio_pkg::mem_req_t  mem_i,
    input  mmio_pkg::spi_cfg_t  spi_cfg_i,
    input  logic                spi_start_i,
    input  logic                spi_busy_i,
    input  mmio_pkg::word_t     i2c_xy_i,
    input  logic                i2c_done_i,
    input  logic                slow_i,    // memory forced past the timeout
    input  int                  phase_i,
    output int                  errors_o,
    output int                  dones_o
);

    mmio_pkg::word_t shadow [512];
    logic            shadow_ok [512];
    int              err_cnt = 0;
    int              done_cnt = 0;
    int              test_errs = 0;
    int              cur_phase = 0;
    int              busy_cycles = 0;
    int              strobes = 0;
    logic            prev_busy = 1'b0;
    logic            prev_i2c_done = 1'b0;
    logic            prev_spi_busy = 1'b0;
    logic            slow_acc = 1'b0;
    mmio_pkg::word_t prev_xy = '0;
    mmio_pkg::word_t xy_acc = '0;

    assign errors_o = err_cnt;
    assign dones_o  = done_cnt;

    initial begin
        for (int i = 0; i < 512; i++) begin
            shadow_ok[i] = 1'b0;
            shadow[i]    = '0;
        end
    end

    // expected read data straight from the address map
    function automatic mmio_pkg::word_t expect_rdata(input mmio_pkg::addr_t a, input logic slow,
                                                     input mmio_pkg::word_t mem_word,
                                                     input mmio_pkg::word_t xy);
        if (a == mmio_pkg::I2C_XY_ADDR) begin
            return xy;
        end
        if (a < mmio_pkg::MEM_LIMIT) begin
            return slow ? mmio_pkg::ERR_WORD : mem_word;
        end
        return '0;  // spi regs read back nothing, unmapped too
    endfunction

    function automatic string phase_name(input int p);
        case (p)
            1: return "reset";
            2: return "memory";
            3: return "timeout";
            4: return "i2c";
            5: return "spi";
            6: return "unmapped";
            default: return "other";
        endcase
    endfunction

    task automatic mismatch(input string sig, input mmio_pkg::word_t got,
                            input mmio_pkg::word_t exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, sig, got, exp);
        err_cnt++;
        test_errs++;
    endtask

    task automatic fail_note(input string what);
        $display("ERROR at %0t: %s", $time, what);
        err_cnt++;
        test_errs++;
    endtask

    task automatic check_reset_state();
        if (busy_i !== 1'b0 || done_i !== 1'b0) begin
            fail_note("busy_o or done_o not low around reset");
        end
        if (mem_i.rd_stb !== 1'b0 || mem_i.wr_stb !== 1'b0 || spi_start_i !== 1'b0) begin
            fail_note("a strobe is high around reset");
        end
        if (rdata_i !== '0) begin
            mismatch("rdata_o", rdata_i, '0);
        end
        if (spi_cfg_i !== '0) begin
            fail_note("spi_cfg_o not zero around reset");
        end
    endtask

    // end of a transaction, request still held by the handler
    task automatic check_done();
        logic            is_mem;
        logic [8:0]      idx;
        int              exp_strobes;
        mmio_pkg::word_t exp;
        done_cnt++;
        is_mem      = req_i.addr < mmio_pkg::MEM_LIMIT;
        idx         = req_i.addr[10:2];
        exp_strobes = is_mem ? 1 : 0;
        if (strobes != exp_strobes) begin
            fail_note($sformatf("%0d memory strobes for one access", strobes));
        end
        if (!is_mem && busy_cycles != 1) begin
            fail_note($sformatf("register access took %0d busy cycles", busy_cycles));
        end
        if (req_i.read) begin
            if (is_mem && !slow_acc && !shadow_ok[idx]) begin
                fail_note("read of a memory word that was never written");
            end else begin
                exp = expect_rdata(req_i.addr, slow_acc, shadow[idx], xy_acc);
                if (rdata_i !== exp) begin
                    mismatch("rdata_o", rdata_i, exp);
                end
            end
        end else begin
            if (is_mem && !slow_acc) begin  // abandoned writes leave memory alone
                shadow[idx]    = req_i.wdata;
                shadow_ok[idx] = 1'b1;
            end
            if (req_i.addr == mmio_pkg::SPI_CMD_ADDR) begin
                if (spi_cfg_i.command !== req_i.wdata[7:0]) begin
                    mismatch("spi_cfg_o.command", 32'(spi_cfg_i.command), 32'(req_i.wdata[7:0]));
                end
                if (spi_cfg_i.counter !== req_i.wdata[11:8]) begin
                    mismatch("spi_cfg_o.counter", 32'(spi_cfg_i.counter), 32'(req_i.wdata[11:8]));
                end
                if (spi_start_i !== 1'b0) begin
                    fail_note("spi_start_o pulsed on a command write");
                end
            end
            if (req_i.addr == mmio_pkg::SPI_PARAM_ADDR) begin
                if (spi_cfg_i.parameters !== req_i.wdata) begin
                    mismatch("spi_cfg_o.parameters", spi_cfg_i.parameters, req_i.wdata);
                end
                if (spi_start_i !== 1'b1) begin
                    fail_note("spi_start_o not high together with done_o");
                end
            end
        end
    endtask

    // sample mid cycle, away from both edges
    always @(negedge clk) begin
        if (phase_i != cur_phase) begin
            if (cur_phase > 0) begin
                $display("test %s: %0d errors", phase_name(cur_phase), test_errs);
            end
            cur_phase = phase_i;
            test_errs = 0;
        end
        if (!nRst || phase_i == 1) begin
            check_reset_state();
        end else begin
            if (busy_i && !prev_busy) begin  // accepted at the last rising edge
                busy_cycles = 0;
                strobes     = 0;
                slow_acc    = slow_i;
                xy_acc      = prev_xy;
                if (req_i.addr == mmio_pkg::I2C_XY_ADDR && !prev_i2c_done) begin
                    fail_note("i2c read accepted while i2c_done_i was low");
                end
                if (req_i.addr == mmio_pkg::SPI_PARAM_ADDR && req_i.write && prev_spi_busy) begin
                    fail_note("spi parameter write accepted while spi_busy_i was high");
                end
            end
            if (busy_i) begin
                busy_cycles++;
            end
            if (mem_i.rd_stb || mem_i.wr_stb) begin
                strobes++;
                if (mem_i.addr !== req_i.addr) begin
                    mismatch("mem_o.addr", mem_i.addr, req_i.addr);
                end
                if (mem_i.rd_stb !== req_i.read) begin
                    mismatch("mem_o.rd_stb", 32'(mem_i.rd_stb), 32'(req_i.read));
                end
                if (mem_i.wr_stb && mem_i.wdata !== req_i.wdata) begin
                    mismatch("mem_o.wdata", mem_i.wdata, req_i.wdata);
                end
            end
            if (spi_start_i && !(done_i && req_i.write
                                 && req_i.addr == mmio_pkg::SPI_PARAM_ADDR)) begin
                fail_note("spi_start_o high outside a parameter write done");
            end
            if (done_i) begin
                check_done();
            end
        end
        prev_busy     = busy_i;
        prev_i2c_done = i2c_done_i;
        prev_spi_busy = spi_busy_i;
        prev_xy       = i2c_xy_i;
    end

endmodule

//--- mmio_tb.sv
`timescale 1ns/1ps

module mmio_tb;

    localparam int N_MEM   = 8;
    localparam int N_TXN   = 2 * N_MEM + 3 + 2 + 2 + 3;  // mem, timeout, i2c, spi, unmapped
    localparam int WDOG_NS = (N_TXN * (mmio_pkg::MEM_TIMEOUT + 10) + 40) * 8;

    logic                clk;
    logic                nRst;
    mmio_pkg::mmio_req_t req;
    logic                busy, done;
    mmio_pkg::word_t     rdata;
    mmio_pkg::mem_req_t  mem;
    logic                mem_busy;
    mmio_pkg::word_t     mem_rdata;
    mmio_pkg::spi_cfg_t  spi_cfg;
    logic                spi_start, spi_busy;
    mmio_pkg::word_t     i2c_xy;
    logic                i2c_done;
    logic                slow;      // memory delay past the timeout
    int                  phase;
    int                  errors, dones;
    int                  txns = 0;
    logic [31:0]         lfsr_q = 32'ha1572616;
    mmio_pkg::word_t     mem_arr [512];

    tb_clkgen clkgen_inst (.clk_o(clk));

    mmio_top mmio_top_inst (
        .clk(clk), .nRst(nRst),
        .mmio_req_i(req), .busy_o(busy), .done_o(done), .rdata_o(rdata),
        .mem_o(mem), .mem_busy_i(mem_busy), .mem_rdata_i(mem_rdata),
        .spi_cfg_o(spi_cfg), .spi_start_o(spi_start), .spi_busy_i(spi_busy),
        .i2c_xy_i(i2c_xy), .i2c_done_i(i2c_done)
    );

    mmio_checker checker_inst (
        .clk(clk), .nRst(nRst), .req_i(req), .busy_i(busy), .done_i(done), .rdata_i(rdata),
        .mem_i(mem), .spi_cfg_i(spi_cfg), .spi_start_i(spi_start), .spi_busy_i(spi_busy),
        .i2c_xy_i(i2c_xy), .i2c_done_i(i2c_done), .slow_i(slow), .phase_i(phase),
        .errors_o(errors), .dones_o(dones)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // one handler access, held until the cycle after done
    task automatic run_txn(input logic rd, input mmio_pkg::addr_t a, input mmio_pkg::word_t wd);
        @(posedge clk);
        #1;
        req.read  = rd;
        req.write = !rd;
        req.addr  = a;
        req.wdata = wd;
        do @(negedge clk); while (!done);
        @(posedge clk);
        #1;
        req.read  = 1'b0;
        req.write = 1'b0;
        txns++;
    endtask

    // data memory with random latency
    initial begin : mem_model
        logic [31:0]     d;
        logic [8:0]      idx;
        logic            wr, slow_acc;
        mmio_pkg::word_t wd;
        mem_busy  = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 512; i++) begin
            mem_arr[i] = (32'(i) * 32'h9E3779B1) ^ 32'h5A5A0000;
        end
        forever begin
            @(negedge clk);
            if (nRst && (mem.rd_stb || mem.wr_stb)) begin
                idx      = mem.addr[10:2];
                wr       = mem.wr_stb;
                wd       = mem.wdata;
                slow_acc = slow;
                if (slow_acc) begin
                    d = 32'd24;
                end else begin
                    take_bits(3, d);
                    d = 32'd1 + d % 32'd6;
                end
                @(posedge clk);
                #1 mem_busy = 1'b1;
                repeat (d) @(posedge clk);
                #1;
                if (wr && !slow_acc) begin
                    mem_arr[idx] = wd;  // timed out writes are dropped
                end
                mem_rdata = mem_arr[idx];
                mem_busy  = 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic [31:0]     v;
        mmio_pkg::addr_t addrs [N_MEM];
        req      = '0;
        spi_busy = 1'b0;
        i2c_xy   = '0;
        i2c_done = 1'b0;
        slow     = 1'b0;
        phase    = 1;
        nRst     = 1'b0;
        repeat (16) @(posedge clk);
        #1 nRst = 1'b1;
        repeat (2) @(posedge clk);
        phase = 2;
        for (int i = 0; i < N_MEM; i++) begin
            take_bits(9, v);
            addrs[i] = {21'd0, v[8:0], 2'b00};
            take_bits(32, v);
            run_txn(1'b0, addrs[i], v);
        end
        for (int i = 0; i < N_MEM; i++) begin
            run_txn(1'b1, addrs[i], '0);
        end
        phase = 3;
        slow  = 1'b1;
        run_txn(1'b0, addrs[0], 32'h0BADF00D);
        run_txn(1'b1, addrs[0], '0);
        slow = 1'b0;
        run_txn(1'b1, addrs[0], '0);  // old value still there
        phase = 4;
        for (int k = 0; k < 2; k++) begin
            take_bits(32, v);
            i2c_xy = v;
            fork
                run_txn(1'b1, mmio_pkg::I2C_XY_ADDR, '0);
                begin
                    repeat (5) @(posedge clk);
                    #1 i2c_done = 1'b1;
                end
            join
            i2c_done = 1'b0;
        end
        phase = 5;
        take_bits(32, v);
        run_txn(1'b0, mmio_pkg::SPI_CMD_ADDR, v);
        take_bits(32, v);
        spi_busy = 1'b1;
        fork
            run_txn(1'b0, mmio_pkg::SPI_PARAM_ADDR, v);
            begin
                repeat (6) @(posedge clk);
                #1 spi_busy = 1'b0;
            end
        join
        phase = 6;
        run_txn(1'b1, 32'd5000, '0);
        run_txn(1'b1, addrs[0], '0);  // leaves a nonzero rdata behind
        run_txn(1'b1, mmio_pkg::SPI_CMD_ADDR, '0);  // write only register
        phase = 7;
        repeat (2) @(negedge clk);
        $display("summary: %0d transactions, %0d done pulses, %0d errors", txns, dones, errors);
        if (errors == 0 && dones == txns) begin
            $display("TEST PASSED");
        end else begin
            if (dones != txns) begin
                $display("done pulse count does not match the transaction count");
            end
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WDOG_NS);
        $display("watchdog expired after %0d ns, a transaction never finished", WDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- all.f
mmio_pkg.sv
mmio_decode.sv
mmio_fsm.sv
mmio_wait_timer.sv
spi_cfg_regs.sv
mmio_top.sv
tb_clkgen.sv
mmio_checker.sv
mmio_tb.sv

//--- Makefile
TOP = mmio_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
